// ==== source/gfx_pkg.sv ====
package gfx_pkg;

    // Pixel color, 4 bits each of red, green and blue
    typedef logic [11:0] color12_t;

    // Pixel coordinate or extent, limits the frame to 255 x 255
    typedef logic [7:0] coord_t;

    // Draw command opcodes
    typedef enum logic {
        OP_FILL = 1'b0,  // Solid rectangle into the back buffer
        OP_SWAP = 1'b1   // Exchange front and back buffer
    } draw_op_t;

    // Which of the two RAMs a side is using
    typedef enum logic {
        FB_A = 1'b0,
        FB_B = 1'b1
    } fb_sel_t;

endpackage

// ==== source/fb_write_if.sv ====
`timescale 1ns/1ps

interface fb_write_if;
    import gfx_pkg::*;

    logic     wr_valid;  // One pixel per clk_write edge, no ready
    coord_t   wr_x;
    coord_t   wr_y;
    color12_t wr_color;
    logic     swap_req;  // Single-cycle pulse
    logic     swap_done; // Pulses once the new front buffer is on screen

    // Draw engine side
    modport source (
        output wr_valid, wr_x, wr_y, wr_color, swap_req,
        input  swap_done
    );

    // Framebuffer side
    modport sink (
        input  wr_valid, wr_x, wr_y, wr_color, swap_req,
        output swap_done
    );

endinterface

// ==== source/pixel_ram.sv ====
`timescale 1ns/1ps

module pixel_ram #(
    parameter int DEPTH = 160 * 120
) (
    input  logic                     clk_write,
    input  logic                     clk_read,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  gfx_pkg::color12_t        wdata,
    output gfx_pkg::color12_t        rdata
);
    import gfx_pkg::*;

    color12_t mem [DEPTH];  // Contents undefined until drawn

    always_ff @(posedge clk_write) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle of read latency
    always_ff @(posedge clk_read) begin
        rdata <= mem[raddr];
    end

    // Linearized address must land inside the array
    a_waddr_in_range: assert property (
        @(posedge clk_write) we |-> (int'(waddr) < DEPTH)
    );

endmodule

// ==== source/double_framebuffer.sv ====
`timescale 1ns/1ps

module double_framebuffer #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic              clk_write,
    input  logic              clk_read,
    input  logic              rst,
    fb_write_if.sink          wr,
    input  logic              frame_start,
    input  gfx_pkg::coord_t   read_x,
    input  gfx_pkg::coord_t   read_y,
    output gfx_pkg::color12_t read_data
);
    import gfx_pkg::*;

    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int AW       = $clog2(FB_DEPTH);

    logic [AW-1:0] waddr;
    logic [AW-1:0] raddr;
    color12_t      rdata_a;
    color12_t      rdata_b;

    fb_sel_t write_sel;   // Back buffer, clk_write
    fb_sel_t read_sel;    // Front buffer, clk_read
    fb_sel_t read_sel_d;  // Front buffer aligned with RAM output

    logic req_tgl;        // Flips once per swap request
    logic req_meta;
    logic req_sync;
    logic ack_tgl;        // Follows req_sync once the swap is applied
    logic ack_meta;
    logic ack_sync;
    logic ack_last;
    logic swap_pending;

    assign waddr = AW'(int'(wr.wr_y) * FB_WIDTH + int'(wr.wr_x));
    assign raddr = AW'(int'(read_y) * FB_WIDTH + int'(read_x));

    // Render domain
    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            write_sel <= FB_B;
            req_tgl   <= 1'b0;
            ack_meta  <= 1'b0;
            ack_sync  <= 1'b0;
            ack_last  <= 1'b0;
        end else begin
            if (wr.swap_req) begin
                write_sel <= fb_sel_t'(~write_sel); // Engine stalls until swap_done
                req_tgl   <= ~req_tgl;
            end
            ack_meta <= ack_tgl;
            ack_sync <= ack_meta;
            ack_last <= ack_sync;
        end
    end

    assign wr.swap_done = ack_sync ^ ack_last;  // One pulse per returned toggle

    // Display domain, the front buffer only changes between frames
    assign swap_pending = req_sync ^ ack_tgl;

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            req_meta   <= 1'b0;
            req_sync   <= 1'b0;
            ack_tgl    <= 1'b0;
            read_sel   <= FB_A;
            read_sel_d <= FB_A;
        end else begin
            req_meta   <= req_tgl;
            req_sync   <= req_meta;
            read_sel_d <= read_sel;
            if (frame_start && swap_pending) begin
                read_sel <= fb_sel_t'(~read_sel);
                ack_tgl  <= req_sync;
            end
        end
    end

    pixel_ram #(.DEPTH(FB_DEPTH)) ram_a (
        .clk_write (clk_write),
        .clk_read  (clk_read),
        .we        (wr.wr_valid && (write_sel == FB_A)),
        .waddr     (waddr),
        .raddr     (raddr),
        .wdata     (wr.wr_color),
        .rdata     (rdata_a)
    );

    pixel_ram #(.DEPTH(FB_DEPTH)) ram_b (
        .clk_write (clk_write),
        .clk_read  (clk_read),
        .we        (wr.wr_valid && (write_sel == FB_B)),
        .waddr     (waddr),
        .raddr     (raddr),
        .wdata     (wr.wr_color),
        .rdata     (rdata_b)
    );

    // Second cycle of read latency
    always_ff @(posedge clk_read) begin
        read_data <= (read_sel_d == FB_A) ? rdata_a : rdata_b;
    end

endmodule

// ==== source/draw_engine.sv ====
`timescale 1ns/1ps

module draw_engine #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120
) (
    input  logic              clk_write,
    input  logic              rst,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  gfx_pkg::draw_op_t cmd_op,
    input  gfx_pkg::coord_t   cmd_x,
    input  gfx_pkg::coord_t   cmd_y,
    input  gfx_pkg::coord_t   cmd_w,
    input  gfx_pkg::coord_t   cmd_h,
    input  gfx_pkg::color12_t cmd_color,
    fb_write_if.source        wr
);
    import gfx_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        SWAP_WAIT
    } state_t;

    state_t   state;
    logic     accept;
    logic     swap_pulse;
    logic     fill_empty;
    logic     fill_last;
    logic [8:0] x_far;  // Last column before clipping
    logic [8:0] y_far;
    coord_t   x_clip;
    coord_t   y_clip;
    coord_t   x_start;
    coord_t   x_end;
    coord_t   y_end;
    coord_t   x_cnt;
    coord_t   y_cnt;
    color12_t color_q;

    assign accept = cmd_valid && cmd_ready && (state == IDLE);

    // Clip the far corner to the frame edge
    assign x_far  = {1'b0, cmd_x} + {1'b0, cmd_w} - 9'd1;
    assign y_far  = {1'b0, cmd_y} + {1'b0, cmd_h} - 9'd1;
    assign x_clip = (x_far >= 9'(FB_WIDTH))  ? coord_t'(FB_WIDTH - 1)  : x_far[7:0];
    assign y_clip = (y_far >= 9'(FB_HEIGHT)) ? coord_t'(FB_HEIGHT - 1) : y_far[7:0];

    // Origin outside the frame or zero extent draws nothing
    assign fill_empty = (cmd_w == '0) || (cmd_h == '0) ||
                        (int'(cmd_x) >= FB_WIDTH) || (int'(cmd_y) >= FB_HEIGHT);

    assign fill_last = (x_cnt == x_end) && (y_cnt == y_end);

    always_ff @(posedge clk_write or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            cmd_ready  <= 1'b1;
            swap_pulse <= 1'b0;
        end else begin
            swap_pulse <= accept && (cmd_op == OP_SWAP);
            case (state)
                IDLE: begin
                    if (!cmd_ready) begin
                        cmd_ready <= 1'b1;  // Back from a fully clipped fill
                    end else if (accept) begin
                        cmd_ready <= 1'b0;
                        if (cmd_op == OP_SWAP) begin
                            state <= SWAP_WAIT;
                        end else if (!fill_empty) begin
                            state <= FILL;
                        end
                    end
                end
                FILL: begin
                    if (fill_last) begin
                        state     <= IDLE;
                        cmd_ready <= 1'b1;
                    end
                end
                SWAP_WAIT: begin
                    if (wr.swap_done) begin
                        state     <= IDLE;
                        cmd_ready <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Rectangle walk, row-major
    always_ff @(posedge clk_write) begin
        if (accept) begin
            x_start <= cmd_x;
            x_cnt   <= cmd_x;
            y_cnt   <= cmd_y;
            x_end   <= x_clip;
            y_end   <= y_clip;
            color_q <= cmd_color;
        end else if (state == FILL) begin
            if (x_cnt == x_end) begin
                x_cnt <= x_start;
                y_cnt <= y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    assign wr.wr_valid = (state == FILL);
    assign wr.wr_x     = x_cnt;
    assign wr.wr_y     = y_cnt;
    assign wr.wr_color = color_q;
    assign wr.swap_req = swap_pulse;

    // Clipper output must keep every write on the framebuffer
    a_write_in_bounds: assert property (
        @(posedge clk_write) disable iff (rst)
        wr.wr_valid |-> (int'(wr.wr_x) < FB_WIDTH) && (int'(wr.wr_y) < FB_HEIGHT)
    );

endmodule

// ==== source/scanout.sv ====
`timescale 1ns/1ps

module scanout #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int H_BLANK   = 4,
    parameter int V_BLANK   = 2
) (
    input  logic            clk_read,
    input  logic            rst,
    output gfx_pkg::coord_t read_x,
    output gfx_pkg::coord_t read_y,
    output logic            frame_start,
    output logic            video_valid,
    output gfx_pkg::coord_t video_x,
    output gfx_pkg::coord_t video_y
);
    import gfx_pkg::*;

    localparam int H_TOTAL = FB_WIDTH + H_BLANK;
    localparam int V_TOTAL = FB_HEIGHT + V_BLANK;
    localparam int HW      = $clog2(H_TOTAL + 1);
    localparam int VW      = $clog2(V_TOTAL + 1);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic          active;
    logic          line_end;
    logic          valid_d1;  // RAM stage
    coord_t        x_d1;
    coord_t        y_d1;

    assign line_end    = (h_cnt == HW'(H_TOTAL - 1));
    assign active      = (h_cnt < HW'(FB_WIDTH)) && (v_cnt < VW'(FB_HEIGHT));
    assign frame_start = line_end && (v_cnt == VW'(V_TOTAL - 1)); // Last blank position
    assign read_x      = active ? coord_t'(h_cnt) : '0;
    assign read_y      = active ? coord_t'(v_cnt) : '0;

    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == VW'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Match RAM latency plus output mux
    always_ff @(posedge clk_read or posedge rst) begin
        if (rst) begin
            valid_d1    <= 1'b0;
            video_valid <= 1'b0;
        end else begin
            valid_d1    <= active;
            video_valid <= valid_d1;
        end
    end

    always_ff @(posedge clk_read) begin
        x_d1    <= read_x;
        y_d1    <= read_y;
        video_x <= x_d1;
        video_y <= y_d1;
    end

    // Framebuffer relies on the pulse leading the first address by one cycle
    a_frame_start_lead: assert property (
        @(posedge clk_read) disable iff (rst)
        frame_start |=> active && (read_x == '0) && (read_y == '0)
    );

endmodule

// ==== source/video_top.sv ====
`timescale 1ns/1ps

module video_top #(
    parameter int FB_WIDTH  = 160,
    parameter int FB_HEIGHT = 120,
    parameter int H_BLANK   = 4,
    parameter int V_BLANK   = 2
) (
    input  logic              clk_write,
    input  logic              clk_read,
    input  logic              rst,
    // Command port, clk_write
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  gfx_pkg::draw_op_t cmd_op,
    input  gfx_pkg::coord_t   cmd_x,
    input  gfx_pkg::coord_t   cmd_y,
    input  gfx_pkg::coord_t   cmd_w,
    input  gfx_pkg::coord_t   cmd_h,
    input  gfx_pkg::color12_t cmd_color,
    // Pixel stream, clk_read
    output logic              video_valid,
    output gfx_pkg::coord_t   video_x,
    output gfx_pkg::coord_t   video_y,
    output gfx_pkg::color12_t video_color
);
    import gfx_pkg::*;

    coord_t read_x;
    coord_t read_y;
    logic   frame_start;

    fb_write_if fb_wr ();

    draw_engine #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) i_draw_engine (
        .clk_write (clk_write),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_x     (cmd_x),
        .cmd_y     (cmd_y),
        .cmd_w     (cmd_w),
        .cmd_h     (cmd_h),
        .cmd_color (cmd_color),
        .wr        (fb_wr.source)
    );

    double_framebuffer #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) i_framebuffer (
        .clk_write   (clk_write),
        .clk_read    (clk_read),
        .rst         (rst),
        .wr          (fb_wr.sink),
        .frame_start (frame_start),
        .read_x      (read_x),
        .read_y      (read_y),
        .read_data   (video_color)
    );

    scanout #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT),
        .H_BLANK   (H_BLANK),
        .V_BLANK   (V_BLANK)
    ) i_scanout (
        .clk_read    (clk_read),
        .rst         (rst),
        .read_x      (read_x),
        .read_y      (read_y),
        .frame_start (frame_start),
        .video_valid (video_valid),
        .video_x     (video_x),
        .video_y     (video_y)
    );

endmodule

// ==== verification/tb_video_top.sv ====
`timescale 1ns/1ps

module tb_video_top;
    import gfx_pkg::*;

    localparam int FB_W        = 16;
    localparam int FB_H        = 12;
    localparam int H_BLANK     = 4;
    localparam int V_BLANK     = 2;
    localparam int FRAME_LIMIT = 2 * (FB_W + H_BLANK) * (FB_H + V_BLANK);
    localparam int READY_LIMIT = 4000;  // A swap may wait out a whole frame

    logic     clk_write;
    logic     clk_read;
    logic     rst;
    logic     cmd_valid;
    logic     cmd_ready;
    draw_op_t cmd_op;
    coord_t   cmd_x;
    coord_t   cmd_y;
    coord_t   cmd_w;
    coord_t   cmd_h;
    color12_t cmd_color;
    logic     video_valid;
    coord_t   video_x;
    coord_t   video_y;
    color12_t video_color;

    color12_t front_model [FB_W * FB_H];  // What the screen should show
    color12_t back_model  [FB_W * FB_H];  // What the engine is drawing into
    int       error_count;
    int       timeout_count;
    bit       timed_out;

    video_top #(
        .FB_WIDTH  (FB_W),
        .FB_HEIGHT (FB_H),
        .H_BLANK   (H_BLANK),
        .V_BLANK   (V_BLANK)
    ) i_dut (
        .clk_write   (clk_write),
        .clk_read    (clk_read),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_op      (cmd_op),
        .cmd_x       (cmd_x),
        .cmd_y       (cmd_y),
        .cmd_w       (cmd_w),
        .cmd_h       (cmd_h),
        .cmd_color   (cmd_color),
        .video_valid (video_valid),
        .video_x     (video_x),
        .video_y     (video_y),
        .video_color (video_color)
    );

    initial begin
        clk_read = 1'b0;
        forever #2 clk_read = ~clk_read;
    end

    initial begin
        clk_write = 1'b0;
        #1;  // Write clock trails the read clock
        forever #2 clk_write = ~clk_write;
    end

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        timeout_count++;
        timed_out = 1'b1;
    endtask

    // Clipping rule applied to the back model, returns the pixel count
    function automatic int paint_back(input int x, input int y, input int w, input int h,
                                      input color12_t color);
        int x_last;
        int y_last;
        int row;
        int col;
        int count;
        count = 0;
        if (w == 0 || h == 0 || x >= FB_W || y >= FB_H) begin
            return 0;
        end
        x_last = (x + w - 1 < FB_W) ? x + w - 1 : FB_W - 1;
        y_last = (y + h - 1 < FB_H) ? y + h - 1 : FB_H - 1;
        for (row = y; row <= y_last; row++) begin
            for (col = x; col <= x_last; col++) begin
                back_model[row * FB_W + col] = color;
                count++;
            end
        end
        return count;
    endfunction

    task automatic swap_models();
        color12_t held;
        for (int i = 0; i < FB_W * FB_H; i++) begin
            held          = front_model[i];
            front_model[i] = back_model[i];
            back_model[i]  = held;
        end
    endtask

    // Returns at the negedge where the pulse is seen
    task automatic wait_frame_start();
        int cycles;
        cycles = 0;
        if (timed_out) return;
        do begin
            @(negedge clk_read);
            cycles++;
        end while (!i_dut.frame_start && cycles < FRAME_LIMIT);
        if (!i_dut.frame_start) begin
            note_timeout("no frame_start pulse from the scanout");
        end
    endtask

    task automatic check_frame();
        int pix;
        int cycles;
        wait_frame_start();
        wait_frame_start();
        if (timed_out) return;
        pix    = 0;
        cycles = 0;
        @(negedge clk_read);
        while (!i_dut.frame_start && cycles < FRAME_LIMIT) begin
            if (video_valid) begin
                if (pix < FB_W * FB_H) begin
                    assert (int'(video_x) == pix % FB_W && int'(video_y) == pix / FB_W) else begin
                        $display("Error %0t: pixel %0d at (%0d,%0d), expected (%0d,%0d)",
                                 $time, pix, video_x, video_y, pix % FB_W, pix / FB_W);
                        error_count++;
                    end
                    assert (video_color === front_model[pix]) else begin
                        $display("Error %0t: pixel (%0d,%0d) color %h, expected %h",
                                 $time, pix % FB_W, pix / FB_W, video_color, front_model[pix]);
                        error_count++;
                    end
                end
                pix++;
            end
            cycles++;
            @(negedge clk_read);
        end
        if (!i_dut.frame_start) begin
            note_timeout("frame did not end with a frame_start pulse");
            return;
        end
        assert (pix == FB_W * FB_H) else begin
            $display("Error %0t: frame held %0d valid pixels, expected %0d",
                     $time, pix, FB_W * FB_H);
            error_count++;
        end
    endtask

    task automatic issue_command(input logic [11:0] op, input logic [11:0] x,
                                 input logic [11:0] y, input logic [11:0] w,
                                 input logic [11:0] h, input logic [11:0] color);
        int cycles;
        int low_cycles;
        int pixels;
        cmd_op    = op[0] ? OP_SWAP : OP_FILL;
        cmd_x     = x[7:0];
        cmd_y     = y[7:0];
        cmd_w     = w[7:0];
        cmd_h     = h[7:0];
        cmd_color = color;
        cmd_valid = 1'b1;
        cycles    = 0;
        while (!cmd_ready && cycles < READY_LIMIT) begin
            @(posedge clk_write);
            #1;
            cycles++;
        end
        if (!cmd_ready) begin
            note_timeout("cmd_ready never rose to accept a command");
            return;
        end
        @(posedge clk_write);  // Handshake on this edge
        #1;
        cmd_valid  = 1'b0;
        low_cycles = 0;
        while (!cmd_ready && low_cycles < READY_LIMIT) begin
            low_cycles++;
            @(posedge clk_write);
            #1;
        end
        if (!cmd_ready) begin
            note_timeout("cmd_ready stayed low after a command was accepted");
            return;
        end
        if (op[0]) begin
            swap_models();
        end else begin
            pixels = paint_back(int'(cmd_x), int'(cmd_y), int'(cmd_w), int'(cmd_h), cmd_color);
            assert (low_cycles == ((pixels == 0) ? 1 : pixels)) else begin
                $display("Error %0t: cmd_ready low for %0d cycles, expected %0d",
                         $time, low_cycles, (pixels == 0) ? 1 : pixels);
                error_count++;
            end
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        string       line;
        logic [11:0] op;
        logic [11:0] x;
        logic [11:0] y;
        logic [11:0] w;
        logic [11:0] h;
        logic [11:0] color;
        rst           = 1'b1;
        cmd_valid     = 1'b0;
        cmd_op        = OP_FILL;
        cmd_x         = '0;
        cmd_y         = '0;
        cmd_w         = '0;
        cmd_h         = '0;
        cmd_color     = '0;
        error_count   = 0;
        timeout_count = 0;
        timed_out     = 1'b0;
        repeat (16) begin
            @(posedge clk_write);
            #1;
            assert (cmd_ready && !video_valid) else begin
                $display("Error %0t: in reset cmd_ready=%0b video_valid=%0b, expected 1 and 0",
                         $time, cmd_ready, video_valid);
                error_count++;
            end
        end
        rst = 1'b0;

        fd = $fopen("verification/fill_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/fill_patterns.txt");
            error_count++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                fields = $fgets(line, fd);
                if (fields > 0) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h", op, x, y, w, h, color);
                    if (fields == 6 && op == 12'h2) begin
                        check_frame();  // Front must be unchanged by hidden fills
                    end else if (fields == 6) begin
                        issue_command(op, x, y, w, h, color);
                        if (op[0] && !timed_out) begin
                            check_frame();
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== verification/fill_patterns.txt ====
// Draw commands for tb_video_top, one per line, fields in hex
// op x y w h color   (op 0 fill, 1 swap, 2 compare a frame with no command)
0 00 00 10 0C 00F  // Whole screen into buffer B
1 00 00 00 00 000  // B to front
0 00 00 10 0C 0F0  // Whole screen into buffer A
1 00 00 00 00 000  // A to front
0 02 03 05 04 F00  // Into B and hidden
2 00 00 00 00 000  // Front still A
0 0C 08 08 08 FF0  // Crosses right and bottom edge
0 10 02 04 04 ABC  // Origin right of the frame
0 03 0C 02 02 123  // Origin below the frame
0 05 05 00 03 777  // Zero width
2 00 00 00 00 000  // Front still A
1 00 00 00 00 000  // B to front with its clipped fills
0 0E 00 FF FF 5A5  // Huge extent clipped to two columns
0 00 0B 10 01 0AA  // Bottom row
0 07 04 01 01 FFF  // Single pixel
1 00 00 00 00 000  // A to front
0 00 00 01 0C 333  // Left column into B
0 0F 00 01 01 C0C  // Top right corner
1 00 00 00 00 000  // B to front

// ==== list.f ====
source/gfx_pkg.sv
source/fb_write_if.sv
source/pixel_ram.sv
source/double_framebuffer.sv
source/draw_engine.sv
source/scanout.sv
source/video_top.sv
verification/tb_video_top.sv

// ==== Makefile ====
TOP := tb_video_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)

# Status comes from grep, so a missing pass line fails the target
run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null

clean:
	rm -rf obj_dir
